/* include/asi_macros.svh */
// Width constants for the algorithm-specific instruction unit
// Fixed by the RV32 crypto instructions

`ifndef ASI_MACROS_SVH
`define ASI_MACROS_SVH

// Data path width
`define ASI_XLEN    32

// Micro-op code width, top two bits give the class
`define ASI_UOP_W   5

// SHA3 index post-shift amount
`define ASI_SHAMT_W 2

`endif

/* design/asi_pkg.sv */
// Shared types for the algorithm-specific instruction unit
// Data vectors, micro-op codes and the SubBytes sequencer states

`include "asi_macros.svh"

package asi_pkg;

    typedef logic [`ASI_XLEN-1:0]    xlen_t;   // One register word
    typedef logic [7:0]              byte_t;   // One AES state byte
    typedef logic [`ASI_SHAMT_W-1:0] shamt_t;

    // Class in bits 4:3, 01 AES, 10 SHA2, 11 SHA3
    typedef enum logic [`ASI_UOP_W-1:0] {
        AESSUB_ENC    = 5'b01000,
        AESSUB_ENCROT = 5'b01001,
        AESSUB_DEC    = 5'b01010,
        AESSUB_DECROT = 5'b01011,
        AESMIX_ENC    = 5'b01100,
        AESMIX_DEC    = 5'b01110,
        SHA256_S0     = 5'b10000,
        SHA256_S1     = 5'b10001,
        SHA256_S2     = 5'b10010,
        SHA256_S3     = 5'b10011,
        SHA3_XY       = 5'b11000,
        SHA3_X1       = 5'b11001,
        SHA3_X2       = 5'b11010,
        SHA3_X4       = 5'b11011,
        SHA3_YX       = 5'b11100
    } asi_uop_t;

    typedef enum logic [1:0] {
        IDLE,
        BUSY,   // One byte per cycle
        DONE    // Result valid for one cycle
    } aes_sub_state_t;

    // Multiply by x in GF(2^8), reduction by 11B
    function automatic byte_t xtime(input byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

endpackage

/* design/asi_aes_sbox.sv */
// AES S-box and inverse S-box for one byte
// Field inverse in GF(2^8) mod 11B shared by both directions

`timescale 1ns/10ps

module asi_aes_sbox (
    input  asi_pkg::byte_t din,
    input  logic           inv,
    output asi_pkg::byte_t dout
);
    import asi_pkg::*;

    byte_t inv_aff;   // Inverse affine of din
    byte_t fin;       // Field inverse operand
    byte_t fout;
    byte_t fwd_aff;   // Forward affine of fout

    function automatic byte_t gf_mul(input byte_t a, input byte_t b);
        byte_t p;
        byte_t t;
        p = '0;
        t = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i])
                p = p ^ t;
            t = xtime(t);
        end
        return p;
    endfunction

    // a^254, zero stays zero
    function automatic byte_t gf_inv(input byte_t a);
        byte_t r;
        r = a;
        for (int i = 0; i < 6; i++)
            r = gf_mul(gf_mul(r, r), a);   // a^3, a^7 ... a^127
        return gf_mul(r, r);
    endfunction

    function automatic byte_t rotl(input byte_t v, input int n);
        logic [15:0] d;
        d = {v, v} << n;
        return d[15:8];
    endfunction

    assign inv_aff = rotl(din, 1) ^ rotl(din, 3) ^ rotl(din, 6) ^ 8'h05;
    assign fin     = inv ? inv_aff : din;
    assign fout    = gf_inv(fin);

    // Affine map with constant 63
    assign fwd_aff = fout ^ rotl(fout, 1) ^ rotl(fout, 2) ^ rotl(fout, 3)
                   ^ rotl(fout, 4) ^ 8'h63;

    assign dout = inv ? fout : fwd_aff;

endmodule

/* design/asi_aes_sub.sv */
// Iterative AES SubBytes on one word
// One shared S-box, one byte per cycle, optional rotate left by 8 at the end

`timescale 1ns/10ps

module asi_aes_sub (
    input  logic           g_clk,
    input  logic           rst,
    input  logic           flush,
    input  logic           sub_start,
    input  logic           sub_dec,
    input  logic           sub_rot,
    input  asi_pkg::xlen_t sub_din,
    output logic           sub_done,
    output asi_pkg::xlen_t sub_dout
);
    import asi_pkg::*;

    aes_sub_state_t state;
    logic [1:0]     idx;        // Byte in flight
    xlen_t          word;       // Captured source
    xlen_t          acc;        // Substituted bytes
    logic           dec_q;
    logic           rot_q;
    byte_t          sbox_in;
    byte_t          sbox_out;

    assign sbox_in = word[idx*8 +: 8];

    asi_aes_sbox u_sbox (
        .din  (sbox_in),
        .inv  (dec_q),
        .dout (sbox_out)
    );

    // ------------------------------
    // Sequencer
    always_ff @(posedge g_clk) begin
        if (rst || flush) begin
            state <= IDLE;
            idx   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    idx <= '0;
                    if (sub_start)
                        state <= BUSY;
                end
                BUSY: begin
                    idx <= idx + 2'd1;
                    if (idx == 2'd3)
                        state <= DONE;   // Last byte written this edge
                end
                default: state <= IDLE;  // DONE lasts one cycle
            endcase
        end
    end

    // ------------------------------
    // Operand capture and byte collection
    always_ff @(posedge g_clk) begin
        if (state == IDLE && sub_start) begin
            word  <= sub_din;
            dec_q <= sub_dec;
            rot_q <= sub_rot;
        end
        if (state == BUSY)
            acc[idx*8 +: 8] <= sbox_out;
    end

    assign sub_done = (state == DONE);
    assign sub_dout = rot_q ? {acc[23:0], acc[31:24]} : acc;   // Rotate left by 8

    // Exec holds off new starts until the result is back
    a_start_idle : assert property (@(posedge g_clk) disable iff (rst)
        sub_start |-> state == IDLE);

endmodule

/* design/asi_aes_mix.sv */
// AES MixColumns and InvMixColumns on one column
// Byte 0 of col is row 0

`timescale 1ns/10ps

module asi_aes_mix (
    input  asi_pkg::xlen_t col,
    input  logic           dec,
    output asi_pkg::xlen_t result
);
    import asi_pkg::*;

    byte_t a  [4];   // Column bytes
    byte_t m2 [4];   // Times 2
    byte_t m4 [4];
    byte_t m8 [4];
    byte_t r  [4];

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            a[i]  = col[i*8 +: 8];
            m2[i] = xtime(a[i]);
            m4[i] = xtime(m2[i]);
            m8[i] = xtime(m4[i]);
        end
    end

    // Rows rotate the 2 3 1 1 or e b d 9 pattern
    always_comb begin
        int j1;
        int j2;
        int j3;
        for (int i = 0; i < 4; i++) begin
            j1 = (i + 1) % 4;
            j2 = (i + 2) % 4;
            j3 = (i + 3) % 4;
            if (dec)
                r[i] = (m8[i]  ^ m4[i]  ^ m2[i])    // e
                     ^ (m8[j1] ^ m2[j1] ^ a[j1])    // b
                     ^ (m8[j2] ^ m4[j2] ^ a[j2])    // d
                     ^ (m8[j3] ^ a[j3]);            // 9
            else
                r[i] = m2[i] ^ (m2[j1] ^ a[j1]) ^ a[j2] ^ a[j3];
        end
    end

    assign result = {r[3], r[2], r[1], r[0]};

endmodule

/* design/asi_sha3_index.sv */
// SHA3 lane index arithmetic
// Index is x mod 5 plus 5 times y mod 5, then shifted left by shamt

`timescale 1ns/10ps
`include "asi_macros.svh"

module asi_sha3_index (
    input  asi_pkg::xlen_t  rs1,
    input  asi_pkg::xlen_t  rs2,
    input  asi_pkg::shamt_t shamt,
    input  logic            f_xy,
    input  logic            f_x1,
    input  logic            f_x2,
    input  logic            f_x4,
    input  logic            f_yx,
    output asi_pkg::xlen_t  result
);
    import asi_pkg::*;

    logic [2:0] m1;     // rs1 mod 5
    logic [2:0] m2;     // rs2 mod 5
    logic [2:0] x;
    logic [2:0] y;
    logic [4:0] lane;   // 0 to 24
    logic       any_f;

    function automatic logic [2:0] mod5(input logic [4:0] v);
        logic [4:0] r;
        r = v % 5'd5;
        return r[2:0];
    endfunction

    assign m1 = 3'(rs1 % xlen_t'(5));
    assign m2 = 3'(rs2 % xlen_t'(5));

    always_comb begin
        x = m1;                         // xy form by default
        y = m2;
        if (f_x1) x = mod5(5'(m1) + 5'd1);
        if (f_x2) x = mod5(5'(m1) + 5'd2);
        if (f_x4) x = mod5(5'(m1) + 5'd4);
        if (f_yx) begin
            x = m2;
            y = mod5(5'(m1) * 5'd2 + 5'(m2) * 5'd3);
        end
    end

    assign lane   = 5'(x) + 5'd5 * 5'(y);
    assign any_f  = f_xy || f_x1 || f_x2 || f_x4 || f_yx;
    assign result = {`ASI_XLEN{any_f}} & (xlen_t'(lane) << shamt);

    // Selects come from the exact decode in the execute stage
    always_comb begin
        assert ($onehot0({f_xy, f_x1, f_x2, f_x4, f_yx}))
            else $error("asi_sha3_index: more than one function selected");
    end

endmodule

/* design/asi_issue.sv */
// Issue stage of the algorithm-specific instruction unit
// One-entry pipeline register between the unit input and the execute stage

`timescale 1ns/10ps

module asi_issue (
    input  logic              g_clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              in_valid,
    output logic              in_ready,
    input  asi_pkg::asi_uop_t in_uop,
    input  asi_pkg::xlen_t    in_rs1,
    input  asi_pkg::xlen_t    in_rs2,
    input  asi_pkg::shamt_t   in_shamt,
    output logic              iss_valid,
    input  logic              iss_ready,
    output asi_pkg::asi_uop_t iss_uop,
    output asi_pkg::xlen_t    iss_rs1,
    output asi_pkg::xlen_t    iss_rs2,
    output asi_pkg::shamt_t   iss_shamt
);

    logic full;       // Entry holds an operation
    logic take;

    assign take      = in_valid && in_ready;
    assign in_ready  = !rst && !flush && (!full || iss_ready); // Empty or draining
    assign iss_valid = full;

    always_ff @(posedge g_clk) begin
        if (rst) begin
            full <= 1'b0;
        end else begin
            if (flush)
                full <= 1'b0;          // Drop whatever is waiting
            else if (take)
                full <= 1'b1;
            else if (iss_ready)
                full <= 1'b0;          // Left for execute
        end
    end

    // Payload
    always_ff @(posedge g_clk) begin
        if (take) begin
            iss_uop   <= in_uop;
            iss_rs1   <= in_rs1;
            iss_rs2   <= in_rs2;
            iss_shamt <= in_shamt;
        end
    end

    // Held op must not change under the execute stage
    a_hold_payload : assert property (@(posedge g_clk) disable iff (rst)
        iss_valid && !iss_ready && !flush |=>
            iss_valid && $stable({iss_uop, iss_rs1, iss_rs2, iss_shamt}));

endmodule

/* design/asi_exec.sv */
// Execute stage of the algorithm-specific instruction unit
// Exact decode, SHA-256 sigmas, result select and the output register
// SubBytes runs on the iterative sub unit, all else loads in one cycle

`timescale 1ns/10ps
`include "asi_macros.svh"

module asi_exec (
    input  logic              g_clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              iss_valid,
    output logic              iss_ready,
    input  asi_pkg::asi_uop_t iss_uop,
    input  asi_pkg::xlen_t    iss_rs1,
    input  asi_pkg::xlen_t    iss_rs2,
    input  asi_pkg::shamt_t   iss_shamt,
    output logic              out_valid,
    input  logic              out_ready,
    output asi_pkg::xlen_t    out_result
);
    import asi_pkg::*;

    // ------------------------------
    // Exact decode
    wire insn_aessub_enc    = iss_valid && iss_uop == AESSUB_ENC;
    wire insn_aessub_encrot = iss_valid && iss_uop == AESSUB_ENCROT;
    wire insn_aessub_dec    = iss_valid && iss_uop == AESSUB_DEC;
    wire insn_aessub_decrot = iss_valid && iss_uop == AESSUB_DECROT;
    wire insn_aesmix_enc    = iss_valid && iss_uop == AESMIX_ENC;
    wire insn_aesmix_dec    = iss_valid && iss_uop == AESMIX_DEC;
    wire insn_sha256_s0     = iss_valid && iss_uop == SHA256_S0;
    wire insn_sha256_s1     = iss_valid && iss_uop == SHA256_S1;
    wire insn_sha256_s2     = iss_valid && iss_uop == SHA256_S2;
    wire insn_sha256_s3     = iss_valid && iss_uop == SHA256_S3;
    wire insn_sha3_xy       = iss_valid && iss_uop == SHA3_XY;
    wire insn_sha3_x1       = iss_valid && iss_uop == SHA3_X1;
    wire insn_sha3_x2       = iss_valid && iss_uop == SHA3_X2;
    wire insn_sha3_x4       = iss_valid && iss_uop == SHA3_X4;
    wire insn_sha3_yx       = iss_valid && iss_uop == SHA3_YX;

    wire insn_aes_sub = insn_aessub_enc || insn_aessub_encrot
                     || insn_aessub_dec || insn_aessub_decrot;
    wire insn_aes_mix = insn_aesmix_enc || insn_aesmix_dec;
    wire insn_sha3    = insn_sha3_xy || insn_sha3_x1 || insn_sha3_x2
                     || insn_sha3_x4 || insn_sha3_yx;

    logic  sub_pend;      // SubBytes in the sub unit
    logic  take;          // Op accepted from issue
    logic  load_fast;     // Single-cycle result loads now
    logic  sub_done;
    xlen_t sub_dout;
    xlen_t result_sha2;
    xlen_t result_sha3;
    xlen_t result_aesmix;
    xlen_t result_fast;   // Zero for unknown codes

    function automatic xlen_t ror(input xlen_t v, input int n);
        return (v >> n) | (v << (`ASI_XLEN - n));
    endfunction

    // ------------------------------
    // Result select
    assign result_sha2 =
        {`ASI_XLEN{insn_sha256_s0}} & (ror(iss_rs1, 7)  ^ ror(iss_rs1, 18) ^ (iss_rs1 >> 3))  |
        {`ASI_XLEN{insn_sha256_s1}} & (ror(iss_rs1, 17) ^ ror(iss_rs1, 19) ^ (iss_rs1 >> 10)) |
        {`ASI_XLEN{insn_sha256_s2}} & (ror(iss_rs1, 2)  ^ ror(iss_rs1, 13) ^ ror(iss_rs1, 22)) |
        {`ASI_XLEN{insn_sha256_s3}} & (ror(iss_rs1, 6)  ^ ror(iss_rs1, 11) ^ ror(iss_rs1, 25));

    assign result_fast = {`ASI_XLEN{insn_aes_mix}} & result_aesmix
                       | {`ASI_XLEN{insn_sha3}}    & result_sha3
                       | result_sha2;              // Already gated per sigma

    asi_sha3_index u_sha3 (
        .rs1    (iss_rs1),
        .rs2    (iss_rs2),
        .shamt  (iss_shamt),
        .f_xy   (insn_sha3_xy),
        .f_x1   (insn_sha3_x1),
        .f_x2   (insn_sha3_x2),
        .f_x4   (insn_sha3_x4),
        .f_yx   (insn_sha3_yx),
        .result (result_sha3)
    );

    asi_aes_mix u_mix (
        .col    (iss_rs1),
        .dec    (insn_aesmix_dec),
        .result (result_aesmix)
    );

    asi_aes_sub u_sub (
        .g_clk     (g_clk),
        .rst       (rst),
        .flush     (flush),
        .sub_start (take && insn_aes_sub),
        .sub_dec   (insn_aessub_dec || insn_aessub_decrot),
        .sub_rot   (insn_aessub_encrot || insn_aessub_decrot),
        .sub_din   (iss_rs1),
        .sub_done  (sub_done),
        .sub_dout  (sub_dout)
    );

    // ------------------------------
    // Handshake and output register
    assign iss_ready = !flush && !sub_pend && (!out_valid || out_ready);
    assign take      = iss_valid && iss_ready;
    assign load_fast = take && !insn_aes_sub;

    always_ff @(posedge g_clk) begin
        if (rst || flush) begin
            out_valid <= 1'b0;
            sub_pend  <= 1'b0;
        end else begin
            if (sub_done || load_fast)
                out_valid <= 1'b1;
            else if (out_ready)
                out_valid <= 1'b0;             // Taken downstream
            if (take && insn_aes_sub)
                sub_pend <= 1'b1;
            else if (sub_done)
                sub_pend <= 1'b0;
        end
    end

    always_ff @(posedge g_clk) begin
        if (sub_done)
            out_result <= sub_dout;
        else if (load_fast)
            out_result <= result_fast;
    end

    a_out_hold : assert property (@(posedge g_clk) disable iff (rst)
        out_valid && !out_ready && !flush |=> out_valid && $stable(out_result));

    // Sub unit only answers a start from this stage
    a_done_pend : assert property (@(posedge g_clk) disable iff (rst)
        sub_done |-> sub_pend);

endmodule

/* design/asi_top.sv */
// Algorithm-specific instruction unit for RV32 crypto
// Issue register followed by the execute stage

`timescale 1ns/10ps

module asi_top (
    input  logic              g_clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              in_valid,
    output logic              in_ready,
    input  asi_pkg::asi_uop_t in_uop,
    input  asi_pkg::xlen_t    in_rs1,
    input  asi_pkg::xlen_t    in_rs2,
    input  asi_pkg::shamt_t   in_shamt,
    output logic              out_valid,
    input  logic              out_ready,
    output asi_pkg::xlen_t    out_result
);
    import asi_pkg::*;

    // Issue to execute
    logic     iss_valid;
    logic     iss_ready;
    asi_uop_t iss_uop;
    xlen_t    iss_rs1;
    xlen_t    iss_rs2;
    shamt_t   iss_shamt;

    asi_issue u_issue (
        .g_clk     (g_clk),
        .rst       (rst),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_uop    (in_uop),
        .in_rs1    (in_rs1),
        .in_rs2    (in_rs2),
        .in_shamt  (in_shamt),
        .iss_valid (iss_valid),
        .iss_ready (iss_ready),
        .iss_uop   (iss_uop),
        .iss_rs1   (iss_rs1),
        .iss_rs2   (iss_rs2),
        .iss_shamt (iss_shamt)
    );

    asi_exec u_exec (
        .g_clk      (g_clk),
        .rst        (rst),
        .flush      (flush),
        .iss_valid  (iss_valid),
        .iss_ready  (iss_ready),
        .iss_uop    (iss_uop),
        .iss_rs1    (iss_rs1),
        .iss_rs2    (iss_rs2),
        .iss_shamt  (iss_shamt),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_result (out_result)
    );

endmodule

/* tb/asi_tb.sv */
// Testbench for the algorithm-specific instruction unit
// Directed and random operations checked against a reference model,
// with random output back-pressure and a flush during a SubBytes

`timescale 1ns/10ps

module asi_tb;
    import asi_pkg::*;

    localparam int          CLK_PERIOD = 40;
    localparam int          DRIVE_DLY  = 2;     // After the rising edge
    localparam int          RST_CYCLES = 8;
    localparam int          WAIT_LIMIT = 200;   // Cycles per wait loop
    localparam logic [31:0] SEED       = 32'hdcd2;

    localparam asi_uop_t VALID_UOPS [15] = '{
        AESSUB_ENC, AESSUB_ENCROT, AESSUB_DEC, AESSUB_DECROT, AESMIX_ENC, AESMIX_DEC,
        SHA256_S0, SHA256_S1, SHA256_S2, SHA256_S3,
        SHA3_XY, SHA3_X1, SHA3_X2, SHA3_X4, SHA3_YX};
    localparam xlen_t EDGE_WORDS [3] = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000};

    logic        g_clk;
    logic        rst;
    logic        flush;
    logic        in_valid;
    logic        in_ready;
    asi_uop_t    in_uop;
    xlen_t       in_rs1;
    xlen_t       in_rs2;
    shamt_t      in_shamt;
    logic        out_valid;
    logic        out_ready;
    xlen_t       out_result;

    xlen_t       exp_q[$];        // Expected results in issue order
    xlen_t       last_result;     // Most recent output transfer
    byte_t       fwd_tab [256];
    byte_t       inv_tab [256];
    logic [31:0] stim_state;
    logic [31:0] rdy_state;       // Separate stream for out_ready
    logic        bp_mode;         // Random out_ready when set
    int          n_err;
    int          n_timeout;
    int          n_checked;

    asi_top dut (
        .g_clk      (g_clk),
        .rst        (rst),
        .flush      (flush),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_uop     (in_uop),
        .in_rs1     (in_rs1),
        .in_rs2     (in_rs2),
        .in_shamt   (in_shamt),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_result (out_result)
    );

    initial begin
        g_clk = 1'b0;
        forever #(CLK_PERIOD/2) g_clk = ~g_clk;
    end

    // ------------------------------
    // Random numbers and reference model
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        stim_state = xorshift(stim_state);
        return stim_state;
    endfunction

    function automatic asi_uop_t rand_uop();
        logic [31:0] r;
        r = next_rand();
        if (r[8])
            return VALID_UOPS[r[3:0] % 15];
        return asi_uop_t'(r[4:0]);           // Any code, unknown ones included
    endfunction

    // Shift and add multiply, reduction by 11B
    function automatic byte_t gmul(input byte_t a, input byte_t b);
        byte_t p;
        byte_t t;
        p = 8'h00;
        t = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i])
                p = p ^ t;
            t = t[7] ? ((t << 1) ^ 8'h1b) : (t << 1);
        end
        return p;
    endfunction

    // Field inverse by search, then the affine map bit by bit
    task automatic build_sbox_tables();
        byte_t finv;
        byte_t s;
        for (int v = 0; v < 256; v++) begin
            finv = 8'h00;
            for (int c = 1; c < 256; c++)
                if (gmul(byte_t'(v), byte_t'(c)) == 8'h01)
                    finv = byte_t'(c);
            for (int i = 0; i < 8; i++)
                s[i] = finv[i] ^ finv[(i+4)%8] ^ finv[(i+5)%8] ^ finv[(i+6)%8] ^ finv[(i+7)%8];
            s = s ^ 8'h63;
            fwd_tab[v] = s;
            inv_tab[s] = byte_t'(v);
        end
    endtask

    function automatic xlen_t sub_word(input xlen_t w, input logic dec, input logic rot);
        xlen_t r;
        for (int i = 0; i < 4; i++)
            r[i*8 +: 8] = dec ? inv_tab[w[i*8 +: 8]] : fwd_tab[w[i*8 +: 8]];
        return rot ? {r[23:0], r[31:24]} : r;
    endfunction

    function automatic xlen_t mix_col(input xlen_t w, input logic dec);
        byte_t coef [4];
        byte_t acc;
        xlen_t r;
        if (dec)
            coef = '{8'h0e, 8'h0b, 8'h0d, 8'h09};
        else
            coef = '{8'h02, 8'h03, 8'h01, 8'h01};
        for (int i = 0; i < 4; i++) begin
            acc = 8'h00;
            for (int j = 0; j < 4; j++)
                acc = acc ^ gmul(coef[(j - i + 4) % 4], w[j*8 +: 8]);   // Row i, column j
            r[i*8 +: 8] = acc;
        end
        return r;
    endfunction

    function automatic xlen_t ror32(input xlen_t v, input int n);
        logic [63:0] d;
        d = {v, v} >> n;
        return d[31:0];
    endfunction

    function automatic xlen_t lane_value(input longint unsigned x, input longint unsigned y,
                                         input shamt_t sh);
        logic [63:0] v;
        v = (x + 5 * y) << sh;
        return v[31:0];
    endfunction

    function automatic xlen_t expected_result(input asi_uop_t uop, input xlen_t rs1,
                                              input xlen_t rs2, input shamt_t sh);
        longint unsigned a;
        longint unsigned b;
        a = {32'h0, rs1};
        b = {32'h0, rs2};
        case (uop)
            AESSUB_ENC:    return sub_word(rs1, 1'b0, 1'b0);
            AESSUB_ENCROT: return sub_word(rs1, 1'b0, 1'b1);
            AESSUB_DEC:    return sub_word(rs1, 1'b1, 1'b0);
            AESSUB_DECROT: return sub_word(rs1, 1'b1, 1'b1);
            AESMIX_ENC:    return mix_col(rs1, 1'b0);
            AESMIX_DEC:    return mix_col(rs1, 1'b1);
            SHA256_S0:     return ror32(rs1, 7) ^ ror32(rs1, 18) ^ (rs1 >> 3);
            SHA256_S1:     return ror32(rs1, 17) ^ ror32(rs1, 19) ^ (rs1 >> 10);
            SHA256_S2:     return ror32(rs1, 2) ^ ror32(rs1, 13) ^ ror32(rs1, 22);
            SHA256_S3:     return ror32(rs1, 6) ^ ror32(rs1, 11) ^ ror32(rs1, 25);
            SHA3_XY:       return lane_value(a % 5, b % 5, sh);
            SHA3_X1:       return lane_value((a + 1) % 5, b % 5, sh);
            SHA3_X2:       return lane_value((a + 2) % 5, b % 5, sh);
            SHA3_X4:       return lane_value((a + 4) % 5, b % 5, sh);
            SHA3_YX:       return lane_value(b % 5, (2 * a + 3 * b) % 5, sh);
            default:       return '0;             // Unknown codes
        endcase
    endfunction

    // ------------------------------
    // Driving tasks, all start and end 2 ns after a rising edge
    task automatic send_op(input asi_uop_t uop, input xlen_t rs1, input xlen_t rs2,
                           input shamt_t sh);
        int   waited;
        logic accepted;
        in_valid = 1'b1;
        in_uop   = uop;
        in_rs1   = rs1;
        in_rs2   = rs2;
        in_shamt = sh;
        waited   = 0;
        accepted = 1'b0;
        while (!accepted && waited < WAIT_LIMIT) begin
            @(negedge g_clk);
            accepted = in_ready;   // Taken on the next rising edge
            waited++;
        end
        @(posedge g_clk);
        if (accepted)
            exp_q.push_back(expected_result(uop, rs1, rs2, sh));
        else begin
            n_timeout++;
            $display("Timeout at %0t: in_ready stayed low for operation %s", $time, uop.name());
        end
        #DRIVE_DLY;
        in_valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        do begin
            @(posedge g_clk);
            waited++;
        end while (exp_q.size() != 0 && waited < WAIT_LIMIT);
        if (exp_q.size() != 0) begin
            n_timeout++;
            $display("Timeout at %0t: %0d results never came out", $time, exp_q.size());
            exp_q.delete();
        end
        #DRIVE_DLY;
    endtask

    task automatic check_known(input asi_uop_t uop, input xlen_t rs1, input xlen_t want);
        send_op(uop, rs1, '0, '0);
        drain();
        if (last_result !== want) begin
            n_err++;
            $display("Fail %0t: %s of %h gave %h, known answer %h",
                     $time, uop.name(), rs1, last_result, want);
        end
    endtask

    task automatic check_roundtrip(input asi_uop_t fwd, input asi_uop_t back, input xlen_t w);
        xlen_t mid;
        send_op(fwd, w, '0, '0);
        drain();
        mid = last_result;
        send_op(back, mid, '0, '0);
        drain();
        if (last_result !== w) begin
            n_err++;
            $display("Fail %0t: %s then %s turned %h into %h",
                     $time, fwd.name(), back.name(), w, last_result);
        end
    endtask

    task automatic pulse_flush();
        flush = 1'b1;
        @(posedge g_clk);
        exp_q.delete();            // Nothing in flight survives
        #DRIVE_DLY;
        flush = 1'b0;
    endtask

    // ------------------------------
    // Output back-pressure
    initial begin
        out_ready = 1'b1;
        rdy_state = SEED ^ 32'hffff_0000;
        forever begin
            @(posedge g_clk);
            #DRIVE_DLY;
            rdy_state = xorshift(rdy_state);
            out_ready = bp_mode ? rdy_state[3] : 1'b1;
        end
    end

    // Compare on every output transfer, both handshake signals stable at negedge
    always @(negedge g_clk) begin
        xlen_t want;
        if (!rst && !flush && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                n_err++;
                $display("Unexpected result %h at %0t with nothing outstanding",
                         out_result, $time);
            end else begin
                want        = exp_q.pop_front();
                last_result = out_result;
                n_checked++;
                if (out_result !== want) begin
                    n_err++;
                    $display("Fail %0t: result %h, expected %h", $time, out_result, want);
                end
            end
        end
    end

    // ------------------------------
    // Main sequence
    initial begin
        logic [31:0] r;
        rst         = 1'b1;
        flush       = 1'b0;
        in_valid    = 1'b0;
        in_uop      = AESSUB_ENC;
        in_rs1      = '0;
        in_rs2      = '0;
        in_shamt    = '0;
        bp_mode     = 1'b0;
        stim_state  = SEED;
        last_result = '0;
        n_err       = 0;
        n_timeout   = 0;
        n_checked   = 0;
        build_sbox_tables();

        repeat (RST_CYCLES - 1) @(posedge g_clk);
        @(negedge g_clk);
        if (in_ready !== 1'b0 || out_valid !== 1'b0) begin
            n_err++;
            $display("Fail %0t: in_ready or out_valid high during reset", $time);
        end
        @(posedge g_clk);
        #DRIVE_DLY;
        rst = 1'b0;
        @(negedge g_clk);
        if (in_ready !== 1'b1) begin
            n_err++;
            $display("Fail %0t: in_ready still low after reset", $time);
        end
        @(posedge g_clk);
        #DRIVE_DLY;

        // SHA-256 sigmas, edge words then random
        for (int k = 6; k < 10; k++) begin
            for (int e = 0; e < 3; e++)
                send_op(VALID_UOPS[k], EDGE_WORDS[e], next_rand(), '0);
            for (int n = 0; n < 8; n++)
                send_op(VALID_UOPS[k], next_rand(), next_rand(), '0);
        end
        drain();

        // SHA3 index forms with every shift
        for (int k = 10; k < 15; k++)
            for (int s = 0; s < 4; s++)
                for (int n = 0; n < 4; n++)
                    send_op(VALID_UOPS[k], next_rand(), next_rand(), shamt_t'(s));
        drain();

        // SubBytes, 00 to 63 and 53 to ED
        check_known(AESSUB_ENC, 32'h0000_5300, 32'h6363_ed63);
        check_known(AESSUB_ENCROT, 32'h0000_5300, 32'h63ed_6363);
        check_known(AESSUB_DEC, 32'h6363_ed63, 32'h0000_5300);
        for (int k = 0; k < 4; k++)
            for (int n = 0; n < 6; n++)
                send_op(VALID_UOPS[k], next_rand(), next_rand(), '0);
        drain();
        for (int n = 0; n < 6; n++)
            check_roundtrip(AESSUB_ENC, AESSUB_DEC, next_rand());

        // MixColumns, known column then random
        check_known(AESMIX_ENC, 32'h4553_13db, 32'hbca1_4d8e);
        for (int n = 0; n < 8; n++) begin
            send_op(AESMIX_ENC, next_rand(), '0, '0);
            send_op(AESMIX_DEC, next_rand(), '0, '0);
        end
        drain();
        for (int n = 0; n < 6; n++)
            check_roundtrip(AESMIX_ENC, AESMIX_DEC, next_rand());

        // Random mix under back-pressure, with idle gaps
        bp_mode = 1'b1;
        for (int n = 0; n < 300; n++) begin
            r = next_rand();
            send_op(rand_uop(), next_rand(), next_rand(), shamt_t'(r[1:0]));
            if (r[12:11] == 2'b00) begin
                @(posedge g_clk);
                #DRIVE_DLY;
            end
        end
        drain();
        bp_mode = 1'b0;

        // Flush with a SubBytes running and a SHA op waiting in issue
        send_op(AESSUB_ENC, next_rand(), '0, '0);
        send_op(SHA256_S1, next_rand(), '0, '0);
        pulse_flush();
        repeat (10) @(posedge g_clk);   // Any output here is unexpected
        #DRIVE_DLY;
        send_op(SHA3_YX, next_rand(), next_rand(), 2'd3);
        send_op(AESSUB_DECROT, next_rand(), '0, '0);
        drain();

        $display("Checked %0d results, %0d errors, %0d timeouts", n_checked, n_err, n_timeout);
        if (n_err == 0 && n_timeout == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* sources.f */
+incdir+include
design/asi_pkg.sv
design/asi_aes_sbox.sv
design/asi_aes_sub.sv
design/asi_aes_mix.sv
design/asi_sha3_index.sv
design/asi_issue.sv
design/asi_exec.sv
design/asi_top.sv
tb/asi_tb.sv

/* Makefile */
# Verilator build and run for the crypto instruction unit

SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal --Mdir obj_dir
TOP      = asi_tb
FILELIST = sources.f
LOG      = sim.log
BIN      = obj_dir/V$(TOP)
SRCS     = $(wildcard include/*.svh design/*.sv tb/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for a failure"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

$(BIN): $(FILELIST) $(SRCS)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

test: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
